//--- hdl/bitonic_sorter.sv
`timescale 1ns/1ps

module bitonic_sorter (
    input  logic              clock,
    input  logic              reset,
    input  logic              valid_i,
    input  sort_pkg::block_t  block_i,
    output logic              valid_o,
    output sort_pkg::block_t  block_o,
    output logic              empty_o
);

    // index 0 is the input, index sort_stages the output
    sort_pkg::block_t stage_block [sort_pkg::sort_stages+1];
    logic [sort_pkg::sort_stages:0] stage_valid;

    assign stage_block[0] = block_i;
    assign stage_valid[0] = valid_i;

    for (genvar s = 0; s < sort_pkg::sort_stages; s++) begin : g_stage
        sort_stage #(
            .stage_index(s),
            .block_size(sort_pkg::block_size)
        ) u_stage (
            .clock(clock),
            .reset(reset),
            .valid_i(stage_valid[s]),
            .block_i(stage_block[s]),
            .valid_o(stage_valid[s+1]),
            .block_o(stage_block[s+1])
        );
    end

    assign valid_o = stage_valid[sort_pkg::sort_stages];
    assign block_o = stage_block[sort_pkg::sort_stages];

    // nothing in flight in any layer
    assign empty_o = ~(|stage_valid[sort_pkg::sort_stages:1]);

endmodule

//--- hdl/block_loader.sv
`timescale 1ns/1ps

module block_loader #(
    parameter int addr_width = 6
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   data_valid_i,
    input  logic                   stream_done_i,
    input  sort_pkg::tuple_t       even_data_i,
    input  sort_pkg::tuple_t       odd_data_i,
    output logic [addr_width-1:0]  row_addr_o,
    output logic                   read_en_o,
    output sort_pkg::block_t       block_o,
    output logic                   block_valid_o,
    output logic                   last_block_o
);

    localparam int rows_per_block = sort_pkg::block_size / 2;
    localparam int offset_bits = $clog2(rows_per_block);
    localparam int tuple_bits = $bits(sort_pkg::tuple_t);

    typedef enum logic [1:0] {
        load_stream,
        load_read,
        load_flush,
        load_idle
    } load_state_t;

    load_state_t state;

    // rows written so far, doubles as the write row
    logic [addr_width:0] stream_len;
    logic [addr_width:0] read_row;
    logic [offset_bits-1:0] offset;
    logic last_offset;

    // bank read data arrives one cycle after the request
    logic cap_valid;
    logic cap_pad;
    logic [offset_bits-1:0] cap_offset;
    logic [offset_bits:0] slot;

    assign read_en_o   = (state == load_read);
    assign row_addr_o  = stream_done_i ? read_row[addr_width-1:0]
                                       : stream_len[addr_width-1:0];
    assign last_offset = (offset == offset_bits'(rows_per_block - 1));
    assign slot        = {cap_offset, 1'b0};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stream count and read sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= load_stream;
            stream_len   <= '0;
            read_row     <= '0;
            offset       <= '0;
            last_block_o <= 1'b0;
        end else begin
            case (state)
                load_stream: begin
                    if (stream_done_i) begin
                        state <= (stream_len == '0) ? load_idle : load_read;
                    end else if (data_valid_i) begin
                        stream_len <= stream_len + 1'b1;
                    end
                end
                load_read: begin
                    read_row <= read_row + 1'b1;
                    offset   <= offset + 1'b1;
                    // stop after the block that covers the last written row
                    if (last_offset && (read_row + 1'b1 >= stream_len)) begin
                        state <= load_flush;
                    end
                end
                load_flush: begin
                    last_block_o <= 1'b1;
                    state        <= load_idle;
                end
                default: begin
                    state <= load_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cap_valid     <= 1'b0;
            block_valid_o <= 1'b0;
        end else begin
            cap_valid     <= read_en_o;
            block_valid_o <= cap_valid && (cap_offset == offset_bits'(rows_per_block - 1));
        end
    end

    // block assembly, rows past the stream become pad
    always_ff @(posedge clock) begin
        cap_offset <= offset;
        cap_pad    <= (read_row >= stream_len);
        if (cap_valid) begin
            block_o[slot*tuple_bits +: tuple_bits] <=
                cap_pad ? sort_pkg::pad_tuple : even_data_i;
            block_o[(slot+1)*tuple_bits +: tuple_bits] <=
                cap_pad ? sort_pkg::pad_tuple : odd_data_i;
        end
    end

endmodule

//--- hdl/block_writer.sv
`timescale 1ns/1ps

module block_writer #(
    parameter int addr_width = 6
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   valid_i,
    input  sort_pkg::block_t       block_i,
    output logic                   write_en_o,
    output logic [addr_width-1:0]  row_addr_o,
    output sort_pkg::tuple_t       even_data_o,
    output sort_pkg::tuple_t       odd_data_o,
    output logic                   block_done_o
);

    localparam int rows_per_block = sort_pkg::block_size / 2;
    localparam int row_bits = $clog2(rows_per_block);
    localparam int tuple_bits = $bits(sort_pkg::tuple_t);

    sort_pkg::block_t shift_q;
    logic active;
    logic [row_bits-1:0] row_cnt;
    // finished blocks, upper bits of the pong row
    logic [addr_width-row_bits-1:0] block_idx;

    assign write_en_o   = active;
    assign row_addr_o   = {block_idx, row_cnt};
    assign even_data_o  = shift_q[tuple_bits-1:0];
    assign odd_data_o   = shift_q[2*tuple_bits-1:tuple_bits];
    assign block_done_o = active && (row_cnt == row_bits'(rows_per_block - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            active    <= 1'b0;
            row_cnt   <= '0;
            block_idx <= '0;
        end else begin
            if (valid_i) begin
                active  <= 1'b1;
                row_cnt <= '0;
            end else if (active) begin
                row_cnt <= row_cnt + 1'b1;
                if (block_done_o) begin
                    active <= 1'b0;
                end
            end
            // a new block may land on the last row of the previous one
            if (block_done_o) begin
                block_idx <= block_idx + 1'b1;
            end
        end
    end

    // lowest slots leave first
    always_ff @(posedge clock) begin
        if (valid_i) begin
            shift_q <= block_i;
        end else begin
            shift_q <= shift_q >> (2 * tuple_bits);
        end
    end

endmodule

//--- hdl/pair_bank.sv
`timescale 1ns/1ps

module pair_bank #(
    parameter int addr_width = 6
) (
    input  logic                   clock,
    input  logic                   write_en_i,
    input  logic                   read_en_i,
    input  logic [addr_width-1:0]  row_addr_i,
    input  sort_pkg::tuple_t       even_data_i,
    input  sort_pkg::tuple_t       odd_data_i,
    output sort_pkg::tuple_t       even_data_o,
    output sort_pkg::tuple_t       odd_data_o
);

    localparam int depth = 2 ** addr_width;

    // one lane per tuple position in a row
    sort_pkg::tuple_t even_mem [depth];
    sort_pkg::tuple_t odd_mem [depth];

    always_ff @(posedge clock) begin
        if (write_en_i) begin
            even_mem[row_addr_i] <= even_data_i;
            odd_mem[row_addr_i]  <= odd_data_i;
        end
        // read data valid the cycle after the address
        if (read_en_i) begin
            even_data_o <= even_mem[row_addr_i];
            odd_data_o  <= odd_mem[row_addr_i];
        end
    end

endmodule

//--- hdl/sort_pkg.sv
package sort_pkg;

    // one range tuple, start in the upper half and end in the lower half
    typedef logic [31:0] tuple_t;

    // tuples per sorted block
    localparam int block_size = 16;

    // all ones, sorts behind every real tuple
    localparam tuple_t pad_tuple = '1;

    // layers in the 16-input bitonic network
    localparam int sort_stages = 10;

    // flat block, slot 0 in the lowest bits
    typedef logic [block_size*$bits(tuple_t)-1:0] block_t;

endpackage

//--- hdl/sort_stage.sv
`timescale 1ns/1ps

module sort_stage #(
    parameter int stage_index = 0,
    parameter int block_size = 16
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              valid_i,
    input  sort_pkg::block_t  block_i,
    output logic              valid_o,
    output sort_pkg::block_t  block_o
);

    localparam int tuple_bits = $bits(sort_pkg::tuple_t);

    // merge phase p has p layers, phase 1 is the pairwise layer
    function automatic int calc_phase(input int idx);
        int acc;
        int ph;
        acc = 0;
        ph = 0;
        for (int p = 1; p <= 8; p++) begin
            if (ph == 0 && idx < acc + p) begin
                ph = p;
            end
            acc = acc + p;
        end
        return ph;
    endfunction

    localparam int phase = calc_phase(stage_index);
    localparam int phase_first = (phase - 1) * phase / 2;
    localparam int merge_size = 1 << phase;
    localparam int distance = 1 << (phase - 1 - (stage_index - phase_first));

    sort_pkg::block_t block_next;

    for (genvar i = 0; i < block_size; i++) begin : g_pair
        if ((i & distance) == 0) begin : g_cmp
            // direction of the bitonic sub-sequence this pair sits in
            localparam bit ascending = ((i & merge_size) == 0);

            sort_pkg::tuple_t lo_val;
            sort_pkg::tuple_t hi_val;
            logic swap;

            assign lo_val = block_i[i*tuple_bits +: tuple_bits];
            assign hi_val = block_i[(i+distance)*tuple_bits +: tuple_bits];
            // whole word compare, start then end
            assign swap = ascending ? (lo_val > hi_val) : (lo_val < hi_val);

            assign block_next[i*tuple_bits +: tuple_bits] = swap ? hi_val : lo_val;
            assign block_next[(i+distance)*tuple_bits +: tuple_bits] =
                swap ? lo_val : hi_val;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clock) begin
        block_o <= block_next;
    end

endmodule

//--- hdl/sort_top.sv
`timescale 1ns/1ps

module sort_top #(
    parameter int addr_width = 6
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   data_valid_i,
    input  logic                   stream_done_i,
    input  sort_pkg::tuple_t       even_data_i,
    input  sort_pkg::tuple_t       odd_data_i,
    input  logic [addr_width-1:0]  rd_addr_i,
    output sort_pkg::tuple_t       rd_even_o,
    output sort_pkg::tuple_t       rd_odd_o,
    output logic                   done_o
);

    logic [addr_width-1:0] ping_addr;
    logic ping_read_en;
    sort_pkg::tuple_t ping_even;
    sort_pkg::tuple_t ping_odd;

    sort_pkg::block_t load_block;
    logic load_valid;
    logic last_block;

    sort_pkg::block_t sorted_block;
    logic sorted_valid;
    logic sorter_empty;

    logic pong_write_en;
    logic [addr_width-1:0] pong_write_addr;
    logic [addr_width-1:0] pong_addr;
    sort_pkg::tuple_t pong_even;
    sort_pkg::tuple_t pong_odd;
    logic block_done;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ping side, input stream then block loads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    pair_bank #(.addr_width(addr_width)) u_ping (
        .clock(clock),
        .write_en_i(data_valid_i),
        .read_en_i(ping_read_en),
        .row_addr_i(ping_addr),
        .even_data_i(even_data_i),
        .odd_data_i(odd_data_i),
        .even_data_o(ping_even),
        .odd_data_o(ping_odd)
    );

    block_loader #(.addr_width(addr_width)) u_loader (
        .clock(clock),
        .reset(reset),
        .data_valid_i(data_valid_i),
        .stream_done_i(stream_done_i),
        .even_data_i(ping_even),
        .odd_data_i(ping_odd),
        .row_addr_o(ping_addr),
        .read_en_o(ping_read_en),
        .block_o(load_block),
        .block_valid_o(load_valid),
        .last_block_o(last_block)
    );

    bitonic_sorter u_sorter (
        .clock(clock),
        .reset(reset),
        .valid_i(load_valid),
        .block_i(load_block),
        .valid_o(sorted_valid),
        .block_o(sorted_block),
        .empty_o(sorter_empty)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pong side, sorted blocks then result reads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    block_writer #(.addr_width(addr_width)) u_writer (
        .clock(clock),
        .reset(reset),
        .valid_i(sorted_valid),
        .block_i(sorted_block),
        .write_en_o(pong_write_en),
        .row_addr_o(pong_write_addr),
        .even_data_o(pong_even),
        .odd_data_o(pong_odd),
        .block_done_o(block_done)
    );

    // result port owns the address once everything is written
    assign pong_addr = done_o ? rd_addr_i : pong_write_addr;

    pair_bank #(.addr_width(addr_width)) u_pong (
        .clock(clock),
        .write_en_i(pong_write_en),
        .read_en_i(done_o),
        .row_addr_i(pong_addr),
        .even_data_i(pong_even),
        .odd_data_i(pong_odd),
        .even_data_o(rd_even_o),
        .odd_data_o(rd_odd_o)
    );

    // last block written and nothing left in the network
    always_ff @(posedge clock) begin
        if (reset) begin
            done_o <= 1'b0;
        end else if (block_done && last_block && sorter_empty) begin
            done_o <= 1'b1;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -f sim.f --top-module tb_sort_top -o sim_tb
out=$(./obj_dir/sim_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1

//--- sim.f
hdl/sort_pkg.sv
hdl/pair_bank.sv
hdl/block_loader.sv
hdl/sort_stage.sv
hdl/bitonic_sorter.sv
hdl/block_writer.sv
hdl/sort_top.sv
tb/tb_sort_top.sv

//--- tb/sort_patterns.txt
// word 0 is the tuple count, then the input tuples in stream order (start high, end low)
// then the expected pong rows, two rows per line as even odd even odd
00000036
// input block 0, duplicate starts 0001 0010 0040
00400050 00100020 00400045 00050009
01200130 00100018 03000310 00020003
02000210 00400048 00770088 00010fff
02500251 00010002 009900a0 01500160
// input block 1
10001100 0a000b00 0c000c10 08000900
0a000a80 0e000f00 0b000b01 09000999
0d000d50 0c000c05 0f000f80 08500860
0e000e10 0a500a60 0d800d90 09500955
// input block 2, upper half of the unsigned range
80008001 7fffffff fff0fff8 20002100
80000001 c000c100 30003333 fffffffe
40004100 a000a100 20002050 60006001
e000e001 50005fff 90009100 b000b100
// input short block of six
03000400 01000200 03000350 00500060
02000201 01000101
// expected block 0
00010002 00010fff 00020003 00050009
00100018 00100020 00400045 00400048
00400050 00770088 009900a0 01200130
01500160 02000210 02500251 03000310
// expected block 1
08000900 08500860 09000999 09500955
0a000a80 0a000b00 0a500a60 0b000b01
0c000c05 0c000c10 0d000d50 0d800d90
0e000e10 0e000f00 0f000f80 10001100
// expected block 2
20002050 20002100 30003333 40004100
50005fff 60006001 7fffffff 80000001
80008001 90009100 a000a100 b000b100
c000c100 e000e001 fff0fff8 fffffffe
// expected short block, padded
00500060 01000101 01000200 02000201
03000350 03000400 ffffffff ffffffff
ffffffff ffffffff ffffffff ffffffff
ffffffff ffffffff ffffffff ffffffff

//--- tb/tb_sort_top.sv
`timescale 1ns/1ps

module tb_sort_top;

    localparam int addr_width = 6;
    localparam int rows_per_block = sort_pkg::block_size / 2;
    // count word, 54 input tuples, 4 expected blocks
    localparam int pat_words = 119;
    localparam int done_timeout = 500;

    logic clock;
    logic reset;
    logic data_valid;
    logic stream_done;
    sort_pkg::tuple_t even_data;
    sort_pkg::tuple_t odd_data;
    logic [addr_width-1:0] rd_addr;
    sort_pkg::tuple_t rd_even;
    sort_pkg::tuple_t rd_odd;
    logic done;

    logic [31:0] pat_mem [0:pat_words-1];
    int tuple_count;
    int block_count;
    int error_count;
    int check_count;

    sort_top #(.addr_width(addr_width)) uut (
        .clock(clock),
        .reset(reset),
        .data_valid_i(data_valid),
        .stream_done_i(stream_done),
        .even_data_i(even_data),
        .odd_data_i(odd_data),
        .rd_addr_i(rd_addr),
        .rd_even_o(rd_even),
        .rd_odd_o(rd_odd),
        .done_o(done)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus order and expected rows
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // reversed run: full blocks reversed as a whole, short tail reversed on its own
    function automatic int input_index(input int pos, input bit reversed);
        int tail_start;
        tail_start = (tuple_count / sort_pkg::block_size) * sort_pkg::block_size;
        if (!reversed) begin
            return pos;
        end
        if (pos < tail_start) begin
            return tail_start - 1 - pos;
        end
        return tuple_count - 1 + tail_start - pos;
    endfunction

    // full blocks land in reverse block order in the reversed run
    function automatic sort_pkg::tuple_t expected_word(input int row, input int slot,
                                                      input bit reversed);
        int full_blocks;
        int blk;
        int src_blk;
        full_blocks = tuple_count / sort_pkg::block_size;
        blk = row / rows_per_block;
        src_blk = blk;
        if (reversed && blk < full_blocks) begin
            src_blk = full_blocks - 1 - blk;
        end
        return pat_mem[1 + tuple_count + src_blk * sort_pkg::block_size
                       + (row % rows_per_block) * 2 + slot];
    endfunction

    task automatic apply_reset();
        @(posedge clock);
        #5;
        reset = 1'b1;
        data_valid = 1'b0;
        stream_done = 1'b0;
        rd_addr = '0;
        repeat (2) @(posedge clock);
        #5;
        reset = 1'b0;
    endtask

    task automatic check_done_low(input string name);
        check_count++;
        if (done !== 1'b0) begin
            $display("%s: done_o is high before the stream was closed", name);
            error_count++;
        end
    endtask

    task automatic stream_tuples(input string name, input bit reversed);
        for (int p = 0; p < tuple_count / 2; p++) begin
            @(posedge clock);
            #5;
            data_valid = 1'b1;
            even_data = pat_mem[1 + input_index(2 * p, reversed)];
            odd_data = pat_mem[1 + input_index(2 * p + 1, reversed)];
            check_done_low(name);
        end
        @(posedge clock);
        #5;
        data_valid = 1'b0;
        // idle gap before the stream closes
        repeat (4) begin
            @(posedge clock);
            #5;
            check_done_low(name);
        end
        stream_done = 1'b1;
    endtask

    task automatic wait_for_done(input string name, output bit seen);
        int cycles;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < done_timeout) begin
            @(posedge clock);
            #5;
            cycles++;
            if (done === 1'b1) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("%s: done_o did not rise within %0d cycles", name, done_timeout);
            error_count++;
        end
    endtask

    task automatic check_results(input string name, input bit reversed);
        sort_pkg::tuple_t exp_even;
        sort_pkg::tuple_t exp_odd;
        for (int r = 0; r < block_count * rows_per_block; r++) begin
            rd_addr = addr_width'(r);
            @(posedge clock);
            #5;
            exp_even = expected_word(r, 0, reversed);
            exp_odd = expected_word(r, 1, reversed);
            check_count += 2;
            if (rd_even !== exp_even) begin
                $display("MISMATCH %s row %0d even: expected %h, actual %h",
                         name, r, exp_even, rd_even);
                error_count++;
            end
            if (rd_odd !== exp_odd) begin
                $display("MISMATCH %s row %0d odd: expected %h, actual %h",
                         name, r, exp_odd, rd_odd);
                error_count++;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        bit seen;
        reset = 1'b1;
        data_valid = 1'b0;
        stream_done = 1'b0;
        even_data = '0;
        odd_data = '0;
        rd_addr = '0;
        error_count = 0;
        check_count = 0;
        $readmemh("tb/sort_patterns.txt", pat_mem);
        tuple_count = int'(pat_mem[0]);
        block_count = (tuple_count + sort_pkg::block_size - 1) / sort_pkg::block_size;
        if (tuple_count <= 0 || tuple_count % 2 != 0
            || 1 + tuple_count + block_count * sort_pkg::block_size > pat_words) begin
            $display("pattern file holds an unusable tuple count of %0d", tuple_count);
            error_count++;
        end else begin
            apply_reset();
            check_done_low("first reset");
            stream_tuples("sorted blocks", 1'b0);
            wait_for_done("sorted blocks", seen);
            if (seen) begin
                check_results("sorted blocks", 1'b0);
            end
            // second run, counters and done must start over
            apply_reset();
            check_done_low("second reset");
            stream_tuples("reversed stream", 1'b1);
            wait_for_done("reversed stream", seen);
            if (seen) begin
                check_results("reversed stream", 1'b1);
            end
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
